// File: asg_macros.svh
/*
  shared widths for the signal generator
  register offsets and buffer select bit
*/
`ifndef ASG_MACROS_SVH
`define ASG_MACROS_SVH

// data path widths
`define ASG_DWO 14  // dac and sample width
`define ASG_DWM 16  // gain width

// read pointer, fixed point
`define ASG_CWM 10  // integer part, table address
`define ASG_CWF 16  // fraction part

`define ASG_TWA 4   // external trigger lines
`define ASG_BUF_BIT 12  // byte address bit for buffer space

// register offsets, low address byte
`define ASG_REG_CTL  8'h00
`define ASG_REG_CFG  8'h04
`define ASG_REG_SIZE 8'h08
`define ASG_REG_OFFS 8'h0C
`define ASG_REG_STEP 8'h10
`define ASG_REG_BCYC 8'h18
`define ASG_REG_BDLY 8'h1C
`define ASG_REG_BNUM 8'h20
`define ASG_REG_LMUL 8'h24
`define ASG_REG_LSUM 8'h28

`endif

// File: asg_pkg.sv
/*
  signal generator types
  sample, pointer, gain and counter vectors, core fsm states
*/
`include "asg_macros.svh"

package asg_pkg;

  typedef logic signed [`ASG_DWO-1:0] sample_t;  // dac sample
  typedef logic [`ASG_CWM+`ASG_CWF-1:0] ptr_t;   // int.frac read pointer
  typedef logic [`ASG_CWM-1:0] addr_t;           // table index

  // gain, 0x4000 is unity
  typedef logic signed [`ASG_DWM-1:0] gain_t;

  typedef logic [15:0] bcnt_t;  // burst cycles and repetitions
  typedef logic [31:0] bdly_t;  // burst delay

  typedef logic [$clog2(`ASG_TWA)-1:0] tsel_t;  // trigger select

  // generator core fsm
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_DATA,
    ST_DELAY
  } core_state_t;

endpackage

// File: asg_regs.sv
/*
  wishbone classic slave for the generator
  configuration registers, ctl strobes, buffer routing
*/
`timescale 1ns/1ps
`include "asg_macros.svh"

module asg_regs (
  input  logic                  bus,
  input  logic                  arst_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [15:0]           wb_adr,     // byte address
  input  logic [31:0]           wb_dat_i,
  output logic [31:0]           wb_dat_o,
  output logic                  wb_ack,
  output logic                  ctl_rst,    // one cycle pulse
  output logic                  trg_sw,     // one cycle pulse
  output asg_pkg::tsel_t        cfg_tsel,
  output logic                  cfg_bena,
  output logic                  cfg_binf,
  output asg_pkg::ptr_t         cfg_size,
  output asg_pkg::ptr_t         cfg_step,
  output asg_pkg::ptr_t         cfg_offs,
  output asg_pkg::bcnt_t        cfg_bcyc,
  output asg_pkg::bdly_t        cfg_bdly,
  output asg_pkg::bcnt_t        cfg_bnum,
  output asg_pkg::gain_t        cfg_lmul,
  output asg_pkg::sample_t      cfg_lsum,
  output logic                  buf_we,
  output asg_pkg::addr_t        buf_addr,
  output asg_pkg::sample_t      buf_wdata,
  input  asg_pkg::sample_t      buf_rdata
);

  logic        acc;        // strobe sampled this cycle
  logic        acc_wr;
  logic        acc_reg;    // register space, not buffer
  logic [7:0]  reg_adr;
  logic        sel_buf;    // read source in ack cycle
  logic [31:0] reg_rdata;

  // no new access in the ack cycle
  assign acc     = wb_cyc & wb_stb & ~wb_ack;
  assign acc_wr  = acc & wb_we;
  assign acc_reg = ~wb_adr[`ASG_BUF_BIT];
  assign reg_adr = wb_adr[7:0];

  ////////////////////////////////////////
  // buffer side
  ////////////////////////////////////////

  assign buf_we    = acc_wr & wb_adr[`ASG_BUF_BIT];
  assign buf_addr  = wb_adr[2 +: `ASG_CWM];  // word index
  assign buf_wdata = wb_dat_i[`ASG_DWO-1:0];

  ////////////////////////////////////////
  // ack, strobes, config writes
  ////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack   <= 1'b0;
      sel_buf  <= 1'b0;
      ctl_rst  <= 1'b0;
      trg_sw   <= 1'b0;
      cfg_tsel <= '0;
      cfg_bena <= 1'b0;
      cfg_binf <= 1'b0;
      cfg_size <= '0;
      cfg_step <= '0;
      cfg_offs <= '0;
      cfg_bcyc <= '0;
      cfg_bdly <= '0;
      cfg_bnum <= '0;
      cfg_lmul <= asg_pkg::gain_t'(1 << (`ASG_DWM-2));  // unity gain
      cfg_lsum <= '0;
    end else begin
      wb_ack <= acc;
      if (acc) sel_buf <= wb_adr[`ASG_BUF_BIT];
      // ctl bits only live for one cycle
      ctl_rst <= acc_wr & acc_reg & (reg_adr == `ASG_REG_CTL) & wb_dat_i[0];
      trg_sw  <= acc_wr & acc_reg & (reg_adr == `ASG_REG_CTL) & wb_dat_i[1];
      if (acc_wr && acc_reg) begin
        case (reg_adr)
          `ASG_REG_CFG: begin
            cfg_tsel <= wb_dat_i[$bits(asg_pkg::tsel_t)-1:0];
            cfg_bena <= wb_dat_i[2];
            cfg_binf <= wb_dat_i[3];
          end
          `ASG_REG_SIZE: cfg_size <= wb_dat_i[`ASG_CWM+`ASG_CWF-1:0];
          `ASG_REG_OFFS: cfg_offs <= wb_dat_i[`ASG_CWM+`ASG_CWF-1:0];
          `ASG_REG_STEP: cfg_step <= wb_dat_i[`ASG_CWM+`ASG_CWF-1:0];
          `ASG_REG_BCYC: cfg_bcyc <= wb_dat_i[15:0];
          `ASG_REG_BDLY: cfg_bdly <= wb_dat_i;
          `ASG_REG_BNUM: cfg_bnum <= wb_dat_i[15:0];
          `ASG_REG_LMUL: cfg_lmul <= wb_dat_i[`ASG_DWM-1:0];
          `ASG_REG_LSUM: cfg_lsum <= wb_dat_i[`ASG_DWO-1:0];
          default: ;  // ctl handled above
        endcase
      end
    end
  end

  // registered read mux, zero extended
  always_ff @(posedge bus) begin
    if (acc) begin
      case (reg_adr)
        `ASG_REG_CFG:  reg_rdata <= {28'h0, cfg_binf, cfg_bena, cfg_tsel};
        `ASG_REG_SIZE: reg_rdata <= {{(32-`ASG_CWM-`ASG_CWF){1'b0}}, cfg_size};
        `ASG_REG_OFFS: reg_rdata <= {{(32-`ASG_CWM-`ASG_CWF){1'b0}}, cfg_offs};
        `ASG_REG_STEP: reg_rdata <= {{(32-`ASG_CWM-`ASG_CWF){1'b0}}, cfg_step};
        `ASG_REG_BCYC: reg_rdata <= {16'h0, cfg_bcyc};
        `ASG_REG_BDLY: reg_rdata <= cfg_bdly;
        `ASG_REG_BNUM: reg_rdata <= {16'h0, cfg_bnum};
        `ASG_REG_LMUL: reg_rdata <= {{(32-`ASG_DWM){1'b0}}, cfg_lmul};
        `ASG_REG_LSUM: reg_rdata <= {{(32-`ASG_DWO){1'b0}}, cfg_lsum};
        default:       reg_rdata <= '0;  // ctl is write only
      endcase
    end
  end

  assign wb_dat_o = sel_buf ? {{(32-`ASG_DWO){1'b0}}, buf_rdata} : reg_rdata;

endmodule

// File: asg_buffer.sv
/*
  sample table ram
  bus write and read port, synchronous generator read port
*/
`timescale 1ns/1ps
`include "asg_macros.svh"

module asg_buffer (
  input  logic             bus,
  input  logic             buf_we,
  input  asg_pkg::addr_t   buf_addr,
  input  asg_pkg::sample_t buf_wdata,
  output asg_pkg::sample_t buf_rdata,
  input  logic             rd_en,
  input  asg_pkg::addr_t   rd_addr,
  output asg_pkg::sample_t rd_data,
  output logic             rd_vld     // aligned with rd_data
);

  asg_pkg::sample_t mem [0:(1 << `ASG_CWM)-1];  // 1024 entries

  // bus port, read returns old data on a write
  always_ff @(posedge bus) begin
    if (buf_we) mem[buf_addr] <= buf_wdata;
    buf_rdata <= mem[buf_addr];
  end

  // generator port
  always_ff @(posedge bus) begin
    if (rd_en) rd_data <= mem[rd_addr];
    rd_vld <= rd_en;  // one cycle ram latency
  end

endmodule

// File: asg_core.sv
/*
  generator core
  trigger select and edge detect, fixed point read pointer,
  continuous and burst fsm
*/
`timescale 1ns/1ps
`include "asg_macros.svh"

module asg_core (
  input  logic                bus,
  input  logic                arst_n,
  input  logic                ctl_rst,
  input  logic                trg_sw,
  input  logic [`ASG_TWA-1:0] trg_ext,
  input  asg_pkg::tsel_t      cfg_tsel,
  input  logic                cfg_bena,
  input  logic                cfg_binf,
  input  asg_pkg::ptr_t       cfg_size,
  input  asg_pkg::ptr_t       cfg_step,
  input  asg_pkg::ptr_t       cfg_offs,
  input  asg_pkg::bcnt_t      cfg_bcyc,
  input  asg_pkg::bdly_t      cfg_bdly,
  input  asg_pkg::bcnt_t      cfg_bnum,
  output logic                rd_en,
  output asg_pkg::addr_t      rd_addr,
  output logic                trg_out
);

  asg_pkg::core_state_t state;
  asg_pkg::ptr_t        ptr;      // int.frac position
  asg_pkg::ptr_t        ptr_nxt;
  asg_pkg::bcnt_t       cnt_cyc;  // reads in current burst
  asg_pkg::bcnt_t       cnt_num;  // bursts done
  asg_pkg::bdly_t       cnt_dly;  // delay cycles done
  logic [`ASG_CWM+`ASG_CWF:0] ptr_sum;  // one extra bit for compare
  logic [`ASG_CWM+`ASG_CWF:0] ptr_sub;
  logic trg_sel;
  logic trg_dly;
  logic trg;
  logic cyc_last;
  logic dly_last;

  ////////////////////////////////////////
  // trigger
  ////////////////////////////////////////

  assign trg_sel = trg_ext[cfg_tsel];
  assign trg     = trg_sw | (trg_sel & ~trg_dly);  // sw or rising edge

  ////////////////////////////////////////
  // pointer step with wrap at size
  ////////////////////////////////////////

  assign ptr_sum = {1'b0, ptr} + {1'b0, cfg_step};
  assign ptr_sub = ptr_sum - {1'b0, cfg_size};
  assign ptr_nxt = (ptr_sum >= {1'b0, cfg_size}) ? ptr_sub[`ASG_CWM+`ASG_CWF-1:0]
                                                 : ptr_sum[`ASG_CWM+`ASG_CWF-1:0];

  assign rd_en   = (state == asg_pkg::ST_DATA);
  assign rd_addr = ptr[`ASG_CWF +: `ASG_CWM];  // integer part only

  // zero counts behave like one
  assign cyc_last = (cnt_cyc + asg_pkg::bcnt_t'(1)) >= cfg_bcyc;
  assign dly_last = (cnt_dly + asg_pkg::bdly_t'(1)) >= cfg_bdly;

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      state   <= asg_pkg::ST_IDLE;
      ptr     <= '0;
      cnt_cyc <= '0;
      cnt_num <= '0;
      cnt_dly <= '0;
      trg_dly <= 1'b0;
      trg_out <= 1'b0;
    end else begin
      trg_dly <= trg_sel;
      trg_out <= 1'b0;
      if (ctl_rst) begin
        state <= asg_pkg::ST_IDLE;  // in flight samples still drain
      end else begin
        case (state)
          asg_pkg::ST_IDLE: if (trg) begin
            ptr     <= cfg_offs;
            cnt_cyc <= '0;
            cnt_num <= '0;
            trg_out <= 1'b1;  // start notification
            state   <= asg_pkg::ST_DATA;
          end
          asg_pkg::ST_DATA: begin
            ptr <= ptr_nxt;
            if (cfg_bena) begin  // continuous mode never leaves
              if (cyc_last) begin
                cnt_cyc <= '0;
                cnt_num <= cnt_num + asg_pkg::bcnt_t'(1);
                cnt_dly <= '0;
                state   <= asg_pkg::ST_DELAY;
              end else begin
                cnt_cyc <= cnt_cyc + asg_pkg::bcnt_t'(1);
              end
            end
          end
          asg_pkg::ST_DELAY: begin
            if (dly_last) begin
              if (cfg_binf || (cnt_num < cfg_bnum)) begin
                ptr   <= cfg_offs;  // each burst restarts at offs
                state <= asg_pkg::ST_DATA;
              end else begin
                state <= asg_pkg::ST_IDLE;
              end
            end else begin
              cnt_dly <= cnt_dly + asg_pkg::bdly_t'(1);
            end
          end
          default: state <= asg_pkg::ST_IDLE;
        endcase
      end
    end
  end

endmodule

// File: asg_linear.sv
/*
  gain and offset stage
  multiply, shift, add offset, saturate, register
*/
`timescale 1ns/1ps
`include "asg_macros.svh"

module asg_linear (
  input  logic             bus,
  input  logic             arst_n,
  input  asg_pkg::sample_t in_dat,
  input  logic             in_vld,
  input  asg_pkg::gain_t   cfg_lmul,
  input  asg_pkg::sample_t cfg_lsum,
  output asg_pkg::sample_t dac_dat,
  output logic             dac_vld
);

  logic signed [`ASG_DWO+`ASG_DWM-1:0] mul;  // full product
  logic signed [`ASG_DWO+1:0]          mul_sh;  // product >> 14
  logic signed [`ASG_DWO+2:0]          sum;
  asg_pkg::sample_t                    sat;

  assign mul    = in_dat * cfg_lmul;
  assign mul_sh = mul[`ASG_DWO+`ASG_DWM-1:`ASG_DWM-2];
  assign sum    = mul_sh + cfg_lsum;

  // clip when the top bits disagree
  always_comb begin
    if (sum[`ASG_DWO+2:`ASG_DWO-1] != {4{sum[`ASG_DWO+2]}}) begin
      sat = sum[`ASG_DWO+2] ? {1'b1, {(`ASG_DWO-1){1'b0}}}   // most negative
                            : {1'b0, {(`ASG_DWO-1){1'b1}}};  // most positive
    end else begin
      sat = sum[`ASG_DWO-1:0];
    end
  end

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      dac_dat <= '0;
      dac_vld <= 1'b0;
    end else begin
      dac_vld <= in_vld;
      if (in_vld) dac_dat <= sat;  // hold last sample
    end
  end

endmodule

// File: asg_top.sv
/*
  arbitrary signal generator top
  register block, sample buffer, core and linear stage
*/
`timescale 1ns/1ps
`include "asg_macros.svh"

module asg_top (
  input  logic                bus,
  input  logic                arst_n,
  // wishbone classic slave
  input  logic                wb_cyc,
  input  logic                wb_stb,
  input  logic                wb_we,
  input  logic [15:0]         wb_adr,
  input  logic [31:0]         wb_dat_i,
  output logic [31:0]         wb_dat_o,
  output logic                wb_ack,
  // triggers
  input  logic [`ASG_TWA-1:0] trg_ext,
  output logic                trg_out,
  // dac
  output asg_pkg::sample_t    dac_dat,
  output logic                dac_vld
);

  // config and control
  logic             ctl_rst;
  logic             trg_sw;
  asg_pkg::tsel_t   cfg_tsel;
  logic             cfg_bena;
  logic             cfg_binf;
  asg_pkg::ptr_t    cfg_size;
  asg_pkg::ptr_t    cfg_step;
  asg_pkg::ptr_t    cfg_offs;
  asg_pkg::bcnt_t   cfg_bcyc;
  asg_pkg::bdly_t   cfg_bdly;
  asg_pkg::bcnt_t   cfg_bnum;
  asg_pkg::gain_t   cfg_lmul;
  asg_pkg::sample_t cfg_lsum;
  // bus to buffer
  logic             buf_we;
  asg_pkg::addr_t   buf_addr;
  asg_pkg::sample_t buf_wdata;
  asg_pkg::sample_t buf_rdata;
  // core to buffer to linear
  logic             rd_en;
  asg_pkg::addr_t   rd_addr;
  asg_pkg::sample_t rd_data;
  logic             rd_vld;

  asg_regs asg_regs_inst (
    .bus, .arst_n,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_dat_o, .wb_ack,
    .ctl_rst, .trg_sw,
    .cfg_tsel, .cfg_bena, .cfg_binf, .cfg_size, .cfg_step, .cfg_offs,
    .cfg_bcyc, .cfg_bdly, .cfg_bnum, .cfg_lmul, .cfg_lsum,
    .buf_we, .buf_addr, .buf_wdata, .buf_rdata
  );

  asg_buffer asg_buffer_inst (
    .bus,
    .buf_we, .buf_addr, .buf_wdata, .buf_rdata,
    .rd_en, .rd_addr, .rd_data, .rd_vld
  );

  asg_core asg_core_inst (
    .bus, .arst_n,
    .ctl_rst, .trg_sw, .trg_ext,
    .cfg_tsel, .cfg_bena, .cfg_binf, .cfg_size, .cfg_step, .cfg_offs,
    .cfg_bcyc, .cfg_bdly, .cfg_bnum,
    .rd_en, .rd_addr, .trg_out
  );

  // rd_en to dac is two cycles
  asg_linear asg_linear_inst (
    .bus, .arst_n,
    .in_dat (rd_data),
    .in_vld (rd_vld),
    .cfg_lmul, .cfg_lsum,
    .dac_dat, .dac_vld
  );

endmodule

// File: tb_asg_top.sv
/*
  directed testbench for the signal generator
  wishbone driver, dac monitor, pointer and gain model, tests
*/
`timescale 1ns/1ps
`include "asg_macros.svh"

module tb_asg_top;

  logic                bus;
  logic                arst_n;
  logic                wb_cyc;
  logic                wb_stb;
  logic                wb_we;
  logic [15:0]         wb_adr;
  logic [31:0]         wb_dat_i;
  logic [31:0]         wb_dat_o;
  logic                wb_ack;
  logic [`ASG_TWA-1:0] trg_ext;
  logic                trg_out;
  asg_pkg::sample_t    dac_dat;
  logic                dac_vld;

  integer           seed;
  asg_pkg::sample_t table_mem [0:15];  // model copy of the loaded table
  asg_pkg::sample_t samples[$];        // collected dac output
  asg_pkg::sample_t exp_q[$];          // model output
  int               trg_cnt;

  asg_top asg_top_inst (.*);

  initial begin
    bus = 1'b0;
    forever #50 bus = ~bus;  // 100 ns period
  end

  // dac monitor sees the values from before the edge
  always @(posedge bus) begin
    if (arst_n && dac_vld) samples.push_back(dac_dat);
    if (arst_n && trg_out) trg_cnt++;
  end

  ////////////////////////////////////////
  // checks and bus driver
  ////////////////////////////////////////

  task stop_on_error(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task check_eq(input string name, input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual)
      stop_on_error($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
  endtask

  task wb_write(input logic [15:0] adr, input logic [31:0] dat);
    int n;
    @(posedge bus);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_i <= dat;
    n = 0;
    do begin
      @(posedge bus);
      n++;
    end while (!wb_ack && n < 10);
    if (!wb_ack) stop_on_error($sformatf("no ack for write to %h", adr));
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task wb_read(input logic [15:0] adr, output logic [31:0] dat);
    int n;
    @(posedge bus);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    n = 0;
    do begin
      @(posedge bus);
      n++;
    end while (!wb_ack && n < 10);
    if (!wb_ack) stop_on_error($sformatf("no ack for read from %h", adr));
    dat = wb_dat_o;  // valid in the ack cycle
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic asg_pkg::sample_t linear_model(input asg_pkg::sample_t x,
                                                    input asg_pkg::gain_t g,
                                                    input asg_pkg::sample_t off);
    int hi;
    int lo;
    int val;
    hi  = (1 << (`ASG_DWO-1)) - 1;
    lo  = -(1 << (`ASG_DWO-1));
    val = ((int'(x) * int'(g)) >>> (`ASG_DWM-2)) + int'(off);  // 0x4000 is unity
    if (val > hi) val = hi;
    else if (val < lo) val = lo;
    return asg_pkg::sample_t'(val);
  endfunction

  // pointer walk from offs with wrap at size
  task add_expected(input int offs, input int step, input int size, input int n,
                    input asg_pkg::gain_t g, input asg_pkg::sample_t off);
    int ptr;
    int k;
    ptr = offs;
    for (k = 0; k < n; k++) begin
      exp_q.push_back(linear_model(table_mem[ptr >> `ASG_CWF], g, off));
      ptr = ptr + step;
      if (ptr >= size) ptr = ptr - size;
    end
  endtask

  function automatic logic [31:0] reg_mask(input logic [7:0] ofs);
    case (ofs)
      `ASG_REG_CFG:  return 32'h0000_000F;
      `ASG_REG_SIZE, `ASG_REG_OFFS, `ASG_REG_STEP: return (32'd1 << (`ASG_CWM+`ASG_CWF)) - 1;
      `ASG_REG_BCYC, `ASG_REG_BNUM: return 32'h0000_FFFF;
      `ASG_REG_LMUL: return (32'd1 << `ASG_DWM) - 1;
      `ASG_REG_LSUM: return (32'd1 << `ASG_DWO) - 1;
      default:       return 32'hFFFF_FFFF;  // bdly uses the full width
    endcase
  endfunction

  function automatic logic [31:0] reset_value(input logic [7:0] ofs);
    return (ofs == `ASG_REG_LMUL) ? 32'h0000_4000 : 32'h0;
  endfunction

  function automatic logic [15:0] buf_adr(input int idx);
    return 16'(1 << `ASG_BUF_BIT) | 16'(idx << 2);  // one word per 4 bytes
  endfunction

  task wait_samples(input int n);
    int i;
    i = 0;
    while (samples.size() < n && i < 200) begin
      @(posedge bus);
      i++;
    end
    if (samples.size() < n) stop_on_error($sformatf("timeout waiting for %0d dac samples", n));
  endtask

  task compare_samples(input string name, input int n);
    int i;
    for (i = 0; i < n; i++)
      check_eq($sformatf("%s sample %0d", name, i), exp_q[i], samples[i]);
  endtask

  // ctl_rst then wait for the pipeline to drain
  task stop_core();
    int i;
    wb_write(16'(`ASG_REG_CTL), 32'h1);
    i = 0;
    while (dac_vld && i < 10) begin
      @(posedge bus);
      i++;
    end
    if (dac_vld) stop_on_error("dac_vld still high after a core reset");
    samples.delete();
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task reg_access();
    logic [7:0]  ofs;
    logic [31:0] word;
    logic [31:0] rd;
    check_eq("reset wb_ack", 32'h0, wb_ack);
    check_eq("reset trg_out", 32'h0, trg_out);
    check_eq("reset dac_vld", 32'h0, dac_vld);
    check_eq("reset dac_dat", 32'h0, dac_dat);
    for (ofs = 8'h04; ofs <= 8'h28; ofs = ofs + 8'h04) begin
      if (ofs != 8'h14) begin  // hole in the map
        wb_read(16'(ofs), rd);
        check_eq($sformatf("reset reg %h", ofs), reset_value(ofs), rd);
        word = $random(seed);
        wb_write(16'(ofs), word);
        wb_read(16'(ofs), rd);
        check_eq($sformatf("readback reg %h", ofs), word & reg_mask(ofs), rd);
        wb_write(16'(ofs), reset_value(ofs));  // back to idle setup
      end
    end
  endtask

  task buf_access();
    int          i;
    logic [31:0] word;
    logic [31:0] rd;
    for (i = 0; i < 16; i++) begin
      word = $random(seed);
      if (i == 6) word = 32'h0000_1FFF;  // max positive for saturation
      if (i == 7) word = 32'hFFFF_2000;  // most negative in 14 bits
      table_mem[i] = word[`ASG_DWO-1:0];
      wb_write(buf_adr(i), word);
    end
    for (i = 0; i < 16; i++) begin
      wb_read(buf_adr(i), rd);
      check_eq($sformatf("buffer word %0d", i), {18'h0, table_mem[i]}, rd);
    end
    word = $random(seed);
    wb_write(buf_adr(1023), word);  // top of the table
    wb_read(buf_adr(1023), rd);
    check_eq("buffer word 1023", word & 32'h3FFF, rd);
  endtask

  task cont_mode();
    wb_write(16'(`ASG_REG_CFG), 32'h0);  // continuous mode with sw trigger
    wb_write(16'(`ASG_REG_SIZE), 32'(8 << `ASG_CWF));
    wb_write(16'(`ASG_REG_OFFS), 32'(5 << `ASG_CWF));
    wb_write(16'(`ASG_REG_STEP), 32'(1 << `ASG_CWF));
    exp_q.delete();
    add_expected(5 << `ASG_CWF, 1 << `ASG_CWF, 8 << `ASG_CWF, 20, 16'h4000, 14'd0);
    samples.delete();
    wb_write(16'(`ASG_REG_CTL), 32'h2);
    wait_samples(20);
    compare_samples("continuous", 20);
    stop_core();
  endtask

  task half_step_gain();
    wb_write(16'(`ASG_REG_OFFS), 32'h0);
    wb_write(16'(`ASG_REG_STEP), 32'h0000_8000);  // 0.5 entry per cycle
    wb_write(16'(`ASG_REG_LMUL), 32'h0000_8000);
    wb_write(16'(`ASG_REG_LSUM), 32'd100);
    exp_q.delete();
    add_expected(0, 32'h8000, 8 << `ASG_CWF, 20, 16'h8000, 14'd100);
    samples.delete();
    wb_write(16'(`ASG_REG_CTL), 32'h2);
    wait_samples(20);
    compare_samples("half step", 20);
    check_eq("half step sat low", 32'hFFFF_E000, samples[12]);  // entry 6
    check_eq("half step sat high", 32'h0000_1FFF, samples[14]);  // entry 7
    stop_core();
    wb_write(16'(`ASG_REG_LMUL), 32'h0000_4000);
    wb_write(16'(`ASG_REG_LSUM), 32'h0);
  endtask

  task soft_stop();
    int i;
    wb_write(16'(`ASG_REG_STEP), 32'(1 << `ASG_CWF));
    samples.delete();
    wb_write(16'(`ASG_REG_CTL), 32'h2);
    wait_samples(5);  // generator is running
    wb_write(16'(`ASG_REG_CTL), 32'h1);
    i = 0;
    while (dac_vld && i < 3) begin
      @(posedge bus);
      i++;
    end
    if (dac_vld) stop_on_error("dac_vld still high 3 cycles after the stop write");
    for (i = 0; i < 20; i++) begin
      @(posedge bus);
      check_eq("stop dac_vld", 32'h0, dac_vld);
    end
    samples.delete();
  endtask

  task burst_ext_trig();
    int i;
    wb_write(16'(`ASG_REG_OFFS), 32'(3 << `ASG_CWF));
    wb_write(16'(`ASG_REG_BCYC), 32'd4);
    wb_write(16'(`ASG_REG_BDLY), 32'd3);
    wb_write(16'(`ASG_REG_BNUM), 32'd2);
    wb_write(16'(`ASG_REG_CFG), 32'h6);  // tsel 2 with burst on
    exp_q.delete();
    add_expected(3 << `ASG_CWF, 1 << `ASG_CWF, 8 << `ASG_CWF, 4, 16'h4000, 14'd0);
    add_expected(3 << `ASG_CWF, 1 << `ASG_CWF, 8 << `ASG_CWF, 4, 16'h4000, 14'd0);
    samples.delete();
    trg_cnt = 0;
    @(posedge bus);
    trg_ext <= 4'b0100;
    wait_samples(8);
    // line stays high through the quiet window, only its edge may start the core
    for (i = 0; i < 50; i++) @(posedge bus);
    check_eq("burst sample count", 32'd8, samples.size());
    check_eq("burst trg_out pulses", 32'd1, trg_cnt);
    compare_samples("burst", 8);
    @(posedge bus);
    trg_ext <= 4'b0000;
  endtask

  initial begin
    seed     = 13;
    trg_cnt  = 0;
    arst_n   = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_i = '0;
    trg_ext  = '0;
    repeat (5) @(posedge bus);
    arst_n <= 1'b1;
    @(posedge bus);
    reg_access();
    buf_access();
    cont_mode();
    half_step_gain();
    soft_stop();
    burst_ext_trig();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: asg_top.f
+incdir+.
asg_pkg.sv
asg_regs.sv
asg_buffer.sv
asg_core.sv
asg_linear.sv
asg_top.sv
tb_asg_top.sv

// File: Makefile
# verilator build and run for the signal generator testbench
# any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_asg_top
FILELIST  ?= asg_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# verdict comes from the log, not the exit code of the pipe
run: compile
	$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
